/* adc_params.svh */
`ifndef ADC_PARAMS_SVH
`define ADC_PARAMS_SVH

// ########################################################################
// build options for the ADC receive front end.
// ########################################################################

// bits per LVDS byte lane.
`define ADC_SAMPLE_W 8

// the FIFO holds 2**ADC_FIFO_AW words.
`define ADC_FIFO_AW 4

// set to 1 to put one more register between capture and the FIFO.
// this eases timing at the cost of one adc_clk cycle of latency.
`define ADC_EXTRA_REG 1

`endif

/* adc_pin_pkg.sv */
`include "adc_params.svh"

// ########################################################################
// types on the ADC pin side of the front end.
// ########################################################################

package adc_pin_pkg;

  // one instant of every input pin of the ADC.
  typedef struct packed {
    logic [`ADC_SAMPLE_W-1:0] di_d;       // I channel, delayed lane.
    logic [`ADC_SAMPLE_W-1:0] di;
    logic [`ADC_SAMPLE_W-1:0] dq_d;       // Q channel, delayed lane.
    logic [`ADC_SAMPLE_W-1:0] dq;
    logic                     overrange;
    logic                     sync;
  } adc_lanes_t;

  // both halves of one adc_clk cycle, aligned to the rising edge.
  typedef struct packed {
    adc_lanes_t rise;
    adc_lanes_t fall;
  } adc_ddr_word_t;

endpackage

/* adc_user_pkg.sv */
`include "adc_params.svh"

// ########################################################################
// types on the user side of the front end.
// ########################################################################

package adc_user_pkg;

  // one realigned ADC cycle as the user sees it.
  // in datai and dataq the index gives time order: 0 is the delayed lane
  // at the rising edge, 1 the undelayed lane at the rising edge, 2 and 3
  // the same pair at the falling edge.
  typedef struct packed {
    logic [1:0]                    sync;       // index 1 is the fall sample.
    logic [1:0]                    overrange;  // same indexing as sync.
    logic [3:0][`ADC_SAMPLE_W-1:0] dataq;
    logic [3:0][`ADC_SAMPLE_W-1:0] datai;
  } adc_user_word_t;

endpackage

/* adc_ddr_capture.sv */
`timescale 1ns/1ps
`include "adc_params.svh"

module adc_ddr_capture (
  input  logic                         adc_clk,
  input  adc_pin_pkg::adc_lanes_t      pins,
  output adc_user_pkg::adc_user_word_t capture_word
);

  import adc_pin_pkg::*;
  import adc_user_pkg::*;

  adc_lanes_t     rise_q;
  adc_lanes_t     fall_hold;
  adc_ddr_word_t  ddr_q;
  adc_user_word_t packed_word;

  // ########################################################################
  // DDR sampling, same edge pipelined.
  // ########################################################################

  always_ff @(posedge adc_clk) begin
    rise_q <= pins;
  end

  // the fall half is held here until the next rising edge.
  always_ff @(negedge adc_clk) begin
    fall_hold <= pins;
  end

  // both halves of one cycle leave together on the rising edge.
  always_ff @(posedge adc_clk) begin
    ddr_q.rise <= rise_q;
    ddr_q.fall <= fall_hold;
  end

  // ########################################################################
  // packing into user order.
  // ########################################################################

  always_comb begin
    packed_word.sync      = {ddr_q.fall.sync, ddr_q.rise.sync};
    packed_word.overrange = {ddr_q.fall.overrange, ddr_q.rise.overrange};

    packed_word.datai[0] = ddr_q.rise.di_d;  // the delayed lane is the older sample.
    packed_word.datai[1] = ddr_q.rise.di;
    packed_word.datai[2] = ddr_q.fall.di_d;
    packed_word.datai[3] = ddr_q.fall.di;

    packed_word.dataq[0] = ddr_q.rise.dq_d;
    packed_word.dataq[1] = ddr_q.rise.dq;
    packed_word.dataq[2] = ddr_q.fall.dq_d;
    packed_word.dataq[3] = ddr_q.fall.dq;
  end

  generate
    if (`ADC_EXTRA_REG) begin : g_extra_reg
      adc_user_word_t extra_q;

      always_ff @(posedge adc_clk) begin
        extra_q <= packed_word;
      end

      assign capture_word = extra_q;  // word of cycle k shows after edge k+2.
    end else begin : g_no_extra_reg
      assign capture_word = packed_word;
    end
  endgenerate

endmodule

/* adc_async_fifo.sv */
`timescale 1ns/1ps
`include "adc_params.svh"

module adc_async_fifo #(
  parameter int WIDTH = 70
) (
  input  logic             dcm_reset,
  input  logic             wr_clk,
  input  logic [WIDTH-1:0] din,
  input  logic             rd_clk,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             empty,
  output logic             drop_seen
);

  localparam int AW    = `ADC_FIFO_AW;
  localparam int DEPTH = 1 << AW;

  logic [WIDTH-1:0] mem [DEPTH];

  // write side, wr_clk domain.
  logic [AW:0] wr_bin;
  logic [AW:0] wr_gray;
  logic [AW:0] rd_gray_s1;
  logic [AW:0] rd_gray_s2;
  logic        full;
  logic        wr_drop;
  logic        drop_tog;

  // read side, rd_clk domain.
  logic [AW:0] rd_bin;
  logic [AW:0] rd_gray;
  logic [AW:0] rd_bin_nxt;
  logic [AW:0] wr_gray_s1;
  logic [AW:0] wr_gray_s2;
  logic        now_empty;
  logic        rd_fire;
  logic [2:0]  drop_sync;

  function automatic logic [AW:0] bin2gray(input logic [AW:0] b);
    return b ^ (b >> 1);
  endfunction

  // ########################################################################
  // write side.
  // ########################################################################

  // full when the write pointer is one lap ahead of the synchronized read pointer.
  assign full    = (wr_gray == {~rd_gray_s2[AW:AW-1], rd_gray_s2[AW-2:0]});
  assign wr_drop = full;  // the write enable is always on.

  always_ff @(posedge wr_clk) begin
    if (dcm_reset) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
      drop_tog   <= 1'b0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
      if (wr_drop) begin
        drop_tog <= ~drop_tog;  // every lost word flips the flag once.
      end else begin
        wr_bin  <= wr_bin + 1'b1;
        wr_gray <= bin2gray(wr_bin + 1'b1);
      end
    end
  end

  always_ff @(posedge wr_clk) begin
    if (!dcm_reset && !full) begin
      mem[wr_bin[AW-1:0]] <= din;
    end
  end

  // ########################################################################
  // read side.
  // ########################################################################

  assign now_empty  = (rd_gray == wr_gray_s2);
  assign rd_fire    = rd_en && !now_empty;
  assign rd_bin_nxt = rd_bin + {{AW{1'b0}}, rd_fire};

  // empty looks past the read of this cycle, so a reader that registers
  // its enable from it never asks for a word that is not there.
  assign empty = (bin2gray(rd_bin_nxt) == wr_gray_s2);

  always_ff @(posedge rd_clk) begin
    if (dcm_reset) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
      drop_sync  <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
      rd_bin     <= rd_bin_nxt;
      rd_gray    <= bin2gray(rd_bin_nxt);
      drop_sync  <= {drop_sync[1:0], drop_tog};
    end
  end

  // a change of the synchronized toggle marks a drop on the write side.
  assign drop_seen = drop_sync[2] ^ drop_sync[1];

  always_ff @(posedge rd_clk) begin
    if (rd_fire) begin
      dout <= mem[rd_bin[AW-1:0]];  // dout holds until the next read.
    end
  end

endmodule

/* adc_user_port.sv */
`timescale 1ns/1ps

module adc_user_port (
  input  logic                         ctrl_clk,
  input  logic                         dcm_reset,
  input  logic                         fifo_empty,
  input  adc_user_pkg::adc_user_word_t fifo_dout,
  input  logic                         drop_seen,
  output logic                         rd_en,
  output adc_user_pkg::adc_user_word_t user_word,
  output logic                         user_valid,
  output logic                         overflow
);

  // ########################################################################
  // read control and status in the ctrl_clk domain.
  // ########################################################################

  // the FIFO keeps its last read word on dout, so that register serves
  // as the output register of the user word.
  assign user_word = fifo_dout;

  always_ff @(posedge ctrl_clk) begin
    if (dcm_reset) begin
      rd_en      <= 1'b0;
      user_valid <= 1'b0;
    end else begin
      rd_en      <= !fifo_empty;  // there is no back-pressure from the user.
      user_valid <= rd_en;        // lines up with the word on dout.
    end
  end

  // overflow is sticky.
  // once a word has been lost only dcm_reset clears it.
  always_ff @(posedge ctrl_clk) begin
    if (dcm_reset) begin
      overflow <= 1'b0;
    end else if (drop_seen) begin
      overflow <= 1'b1;
    end
  end

endmodule

/* adc_interface.sv */
`timescale 1ns/1ps

module adc_interface (
  input  logic                         adc_clk,
  input  logic                         dcm_reset,
  input  logic                         ctrl_reset,
  input  logic                         ctrl_clk,
  input  adc_pin_pkg::adc_lanes_t      pins,
  output logic                         adc_rst,
  output adc_user_pkg::adc_user_word_t user_word,
  output logic                         user_valid,
  output logic                         overflow
);

  import adc_user_pkg::*;

  adc_user_word_t capture_word;
  adc_user_word_t fifo_dout;
  logic           fifo_empty;
  logic           rd_en;
  logic           drop_seen;

  // the ADC reset is a plain copy of the control reset.
  assign adc_rst = ctrl_reset;

  // ########################################################################
  // adc_clk domain.
  // ########################################################################

  adc_ddr_capture adc_ddr_capture_i (
    .adc_clk      (adc_clk),
    .pins         (pins),
    .capture_word (capture_word)
  );

  adc_async_fifo #(
    .WIDTH ($bits(adc_user_word_t))
  ) adc_async_fifo_i (
    .dcm_reset (dcm_reset),
    .wr_clk    (adc_clk),
    .din       (capture_word),
    .rd_clk    (ctrl_clk),
    .rd_en     (rd_en),
    .dout      (fifo_dout),
    .empty     (fifo_empty),
    .drop_seen (drop_seen)
  );

  // ########################################################################
  // ctrl_clk domain.
  // ########################################################################

  adc_user_port adc_user_port_i (
    .ctrl_clk   (ctrl_clk),
    .dcm_reset  (dcm_reset),
    .fifo_empty (fifo_empty),
    .fifo_dout  (fifo_dout),
    .drop_seen  (drop_seen),
    .rd_en      (rd_en),
    .user_word  (user_word),
    .user_valid (user_valid),
    .overflow   (overflow)
  );

endmodule

/* adc_interface_chk.sv */
`timescale 1ns/1ps

module adc_interface_chk (
  input logic clk,
  input logic reset,
  input logic rd_req,
  input logic no_word,
  input logic valid,
  input logic sticky
);

  // ##########################################################################
  // FIFO and user port properties.
  // ##########################################################################

  // the registered read request must never meet an empty FIFO.
  a_no_empty_read : assert property (
    @(posedge clk) disable iff (reset) rd_req |-> !no_word
  ) else $error("FIFO read while empty.");

  a_valid_in_reset : assert property (
    @(posedge clk) reset |=> !valid
  ) else $error("user_valid high during reset.");

  // once set, overflow only drops after a reset.
  a_overflow_sticky : assert property (
    @(posedge clk) (!reset && sticky) |=> sticky
  ) else $error("overflow fell without reset.");

endmodule

bind adc_async_fifo adc_interface_chk fifo_chk_i (
  .clk     (rd_clk),
  .reset   (dcm_reset),
  .rd_req  (rd_en),
  .no_word (now_empty),
  .valid   (1'b0),
  .sticky  (1'b0)
);

bind adc_user_port adc_interface_chk port_chk_i (
  .clk     (ctrl_clk),
  .reset   (dcm_reset),
  .rd_req  (1'b0),
  .no_word (1'b0),
  .valid   (user_valid),
  .sticky  (overflow)
);

/* tb_adc_interface.sv */
`timescale 1ns/1ps

module tb_adc_interface;

  import adc_pin_pkg::*;
  import adc_user_pkg::*;

  localparam int WORD_W = $bits(adc_user_word_t);

  logic           adc_clk;
  logic           ctrl_free;
  logic           ctrl_gate;
  logic           ctrl_clk;
  logic           dcm_reset;
  logic           ctrl_reset;
  adc_lanes_t     pins;
  logic           adc_rst;
  adc_user_word_t user_word;
  logic           user_valid;
  logic           overflow;

  adc_lanes_t     rise_mem[$];
  adc_lanes_t     fall_mem[$];
  string          tag_mem[$];
  adc_user_word_t exp_q[$];
  string          name_q[$];

  logic           synced;      // set once the first test word has been found.
  logic           lossy;       // words may be missing while the FIFO overflows.
  int             cycle_count;
  int             cycle_limit;

  adc_interface adc_interface_i (
    .adc_clk    (adc_clk),
    .dcm_reset  (dcm_reset),
    .ctrl_reset (ctrl_reset),
    .ctrl_clk   (ctrl_clk),
    .pins       (pins),
    .adc_rst    (adc_rst),
    .user_word  (user_word),
    .user_valid (user_valid),
    .overflow   (overflow)
  );

  // ##########################################################################
  // clocks and timeout.
  // ##########################################################################

  always #50 adc_clk = ~adc_clk;

  // ctrl_clk is adc_clk shifted by 30 ns, with a gate to stop it.
  always @(adc_clk) begin
    #30;
    ctrl_free = adc_clk;
  end

  assign ctrl_clk = ctrl_free & ctrl_gate;

  always @(posedge adc_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Done: errors found");
      $fatal(1, "timeout after %0d adc_clk cycles", cycle_count);
    end
  end

  // ##########################################################################
  // helpers.
  // ##########################################################################

  task automatic check_value(input string test, input logic [WORD_W-1:0] expected,
                             input logic [WORD_W-1:0] actual);
    if (actual !== expected) begin
      $display("Fail %s expected %h actual %h", test, expected, actual);
      $display("Done: errors found");
      $fatal(1, "value mismatch in %s", test);
    end
  endtask

  // the user word that one ADC cycle should turn into.
  function automatic adc_user_word_t expected_word(input adc_lanes_t r, input adc_lanes_t f);
    adc_user_word_t w;
    w.sync      = {f.sync, r.sync};
    w.overrange = {f.overrange, r.overrange};
    w.datai     = {f.di, f.di_d, r.di, r.di_d};  // index 0 sits at the low end.
    w.dataq     = {f.dq, f.dq_d, r.dq, r.dq_d};
    return w;
  endfunction

  // rise half on the falling edge, fall half just after the rising edge.
  task automatic drive_cycle(input adc_lanes_t r, input adc_lanes_t f, input string test);
    @(negedge adc_clk);
    pins <= r;
    @(posedge adc_clk);
    #1;
    pins <= f;
    exp_q.push_back(expected_word(r, f));
    name_q.push_back(test);
  endtask

  task automatic drive_filler(input int cycles, input string test);
    adc_lanes_t r;
    adc_lanes_t f;
    repeat (cycles) begin
      r = {$urandom(), 2'b00};
      f = {$urandom(), 2'b00};
      drive_cycle(r, f, test);
    end
  endtask

  task automatic load_testdata();
    int         fd;
    int         n;
    string      line;
    string      tag;
    int         v[12];
    adc_lanes_t r;
    adc_lanes_t f;
    fd = $fopen("adc_testdata.txt", "r");
    if (fd == 0) begin
      $display("Done: errors found");
      $fatal(1, "could not open adc_testdata.txt");
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h", tag,
                  v[0], v[1], v[2], v[3], v[4], v[5],
                  v[6], v[7], v[8], v[9], v[10], v[11]);
      if (n != 13) begin
        $display("Done: errors found");
        $fatal(1, "adc_testdata.txt has a line that does not hold 13 fields");
      end
      r = {v[0][7:0], v[1][7:0], v[2][7:0], v[3][7:0], v[4][0], v[5][0]};
      f = {v[6][7:0], v[7][7:0], v[8][7:0], v[9][7:0], v[10][0], v[11][0]};
      rise_mem.push_back(r);
      fall_mem.push_back(f);
      tag_mem.push_back(tag);
    end
    $fclose(fd);
  endtask

  // ##########################################################################
  // output monitor.
  // ##########################################################################

  initial begin
    forever begin
      @(negedge ctrl_clk);
      if (user_valid === 1'b1 && exp_q.size() > 0) begin
        if (!synced) begin
          if (user_word === exp_q[0]) begin
            synced = 1'b1;
            void'(exp_q.pop_front());
            void'(name_q.pop_front());
          end
        end else if (lossy) begin
          // lost words are skipped, but the order must hold.
          while (exp_q.size() > 0 && exp_q[0] !== user_word) begin
            void'(exp_q.pop_front());
            void'(name_q.pop_front());
          end
          if (exp_q.size() == 0) begin
            $display("delivered word %h is not in the expected stream", user_word);
            $display("Done: errors found");
            $fatal(1, "word out of order during overflow");
          end
          void'(exp_q.pop_front());
          void'(name_q.pop_front());
        end else begin
          check_value(name_q[0], exp_q[0], user_word);
          void'(exp_q.pop_front());
          void'(name_q.pop_front());
        end
      end
    end
  end

  // ##########################################################################
  // main sequence.
  // ##########################################################################

  initial begin
    void'($urandom(19));
    adc_clk     = 1'b0;
    ctrl_free   = 1'b0;
    ctrl_gate   = 1'b1;
    dcm_reset   = 1'b1;
    ctrl_reset  = 1'b1;
    pins        = '0;
    synced      = 1'b0;
    lossy       = 1'b0;
    cycle_count = 0;
    cycle_limit = 0;

    load_testdata();
    cycle_limit = 4 * (rise_mem.size() + 60);

    repeat (5) @(posedge adc_clk);
    @(negedge adc_clk);
    check_value("reset", WORD_W'(0), WORD_W'(user_valid));
    check_value("reset", WORD_W'(0), WORD_W'(overflow));
    check_value("reset", WORD_W'(1), WORD_W'(adc_rst));
    dcm_reset  = 1'b0;
    ctrl_reset = 1'b0;
    #1;
    check_value("reset", WORD_W'(0), WORD_W'(adc_rst));

    for (int i = 0; i < rise_mem.size(); i++) begin
      if (i > 0 && tag_mem[i] != tag_mem[i-1]) drive_filler(3, "idle");
      drive_cycle(rise_mem[i], fall_mem[i], tag_mem[i]);
    end

    // the test words are through the pipeline before any loss is allowed.
    drive_filler(10, "idle");
    check_value("overflow", WORD_W'(0), WORD_W'(overflow));

    // stop the user clock long enough to overrun the FIFO.
    lossy     = 1'b1;
    ctrl_gate = 1'b0;  // just after a rising edge of adc_clk, so ctrl_clk is low here.
    drive_filler(40, "overflow");
    ctrl_gate = 1'b1;
    drive_filler(20, "overflow");

    while (exp_q.size() > 0) @(posedge adc_clk);
    check_value("overflow", WORD_W'(1), WORD_W'(overflow));

    @(negedge adc_clk);
    dcm_reset = 1'b1;
    repeat (5) @(negedge adc_clk);
    check_value("overflow_clear", WORD_W'(0), WORD_W'(overflow));
    check_value("overflow_clear", WORD_W'(0), WORD_W'(user_valid));
    dcm_reset = 1'b0;
    repeat (3) @(negedge adc_clk);
    check_value("overflow_clear", WORD_W'(0), WORD_W'(overflow));

    $display("Done: no errors");
    $finish;
  end

endmodule

/* adc_testdata.txt */
# test | rise: di_d di dq_d dq ovr sync | fall: di_d di dq_d dq ovr sync (hex)
# one line per adc_clk cycle.
lanes 11 12 21 22 0 0 13 14 23 24 0 0
lanes 31 32 41 42 0 0 33 34 43 44 0 0
lanes a0 a1 b0 b1 0 0 a2 a3 b2 b3 0 0
lanes 01 02 03 04 0 0 05 06 07 08 0 0
lanes fe dc ba 98 0 0 76 54 32 10 0 0
overrange 55 66 77 88 1 0 99 aa bb cc 0 0
overrange 12 34 56 78 0 0 9a bc de f0 1 0
overrange c1 c2 c3 c4 1 0 c5 c6 c7 c8 1 0
overrange 00 ff 00 ff 0 0 ff 00 ff 00 0 0
sync 10 20 30 40 0 1 50 60 70 80 0 0
sync 18 28 38 48 0 0 58 68 78 88 0 1
sync 1c 2c 3c 4c 0 1 5c 6c 7c 8c 0 1
sync 3a 4b 5c 6d 0 0 7e 8f 90 a1 0 0
lanes 80 81 82 83 0 0 84 85 86 87 0 0

/* files.f */
+incdir+.
adc_pin_pkg.sv
adc_user_pkg.sv
adc_ddr_capture.sv
adc_async_fifo.sv
adc_user_port.sv
adc_interface.sv
adc_interface_chk.sv
tb_adc_interface.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
  -f files.f \
  --top-module tb_adc_interface \
  -o tb_adc_interface
./obj_dir/tb_adc_interface
